// File: r24_status.f
rtl/r24_status_pkg.sv
rtl/apb_chan_regs.sv
rtl/overrange_stretch.sv
rtl/ioexp_word_builder.sv
rtl/i2c_ioexp_writer.sv
rtl/r24_status_top.sv
testbench/r24_status_tb.sv

// File: Bender.yml
package:
  name: r24_status

sources:
  # Package first, top level last
  - rtl/r24_status_pkg.sv
  - rtl/apb_chan_regs.sv
  - rtl/overrange_stretch.sv
  - rtl/ioexp_word_builder.sv
  - rtl/i2c_ioexp_writer.sv
  - rtl/r24_status_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/r24_status_tb.sv

// File: testbench/r24_status_tb.sv
`default_nettype none

module r24_status_tb;
    import r24_status_pkg::*;

    // Same values as the DUT defaults
    localparam int         HOLD_CYCLES    = 16;
    localparam int         QUARTER_CYCLES = 4;
    localparam logic [6:0] DEV_ADDR       = 7'h20;
    localparam int         QUIET_CYCLES   = 16 * QUARTER_CYCLES;  // Beats the gap between frames
    localparam int         WAIT_LIMIT     = 5000;                 // Cycles per wait loop
    localparam int         N_RANDOM       = 40;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    logic [31:0] prdata;
    logic [1:0]  dor;
    logic        sclk;
    logic        sda;

    chan_cfg_t   ina_m;                  // Model of the two channel registers
    chan_cfg_t   inb_m;
    logic [1:0]  ovr_m;                  // Steady overrange state
    ioexp_word_u last_word;              // Newest decoded word

    // Bus monitor state
    logic        mon_scl_q = 1'b1;
    logic        mon_sda_q = 1'b1;
    logic        mon_in_frame = 1'b0;
    int          mon_bit;
    int          mon_byte;
    logic [7:0]  mon_shift;
    logic [7:0]  mon_bytes [4];
    ioexp_word_u mon_word;
    logic [7:0]  hdr_addr_q [$];
    logic [7:0]  hdr_cmd_q [$];
    ioexp_word_u rx_word_q [$];

    r24_status_top r24_status_top_inst (
        .clk           (clk),
        .reset_i       (reset),
        .apb_req_i     (apb_req),
        .prdata_o      (prdata),
        .dor_i         (dor),
        .ioexp_sclk_o  (sclk),
        .ioexp_sdata_o (sda)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_rdata(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp)
            stop_with_failure($sformatf("error at %0t: %s read 0x%08h, expected 0x%08h",
                                        $time, what, got, exp));
    endtask

    task automatic check_word(ioexp_word_u got, ioexp_word_u exp);
        if (got !== exp)
            stop_with_failure($sformatf("error at %0t: word %02h_%02h, expected %02h_%02h",
                                        $time, got.ports.port1, got.ports.port0,
                                        exp.ports.port1, exp.ports.port0));
    endtask

    task automatic check_hdr(logic [7:0] addr_byte, logic [7:0] cmd_byte);
        if (addr_byte !== {DEV_ADDR, 1'b0} || cmd_byte !== IOEXP_CMD_OUT0)
            stop_with_failure($sformatf("error at %0t: header %02h %02h, expected %02h %02h",
                                        $time, addr_byte, cmd_byte, {DEV_ADDR, 1'b0},
                                        IOEXP_CMD_OUT0));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model
    ////////////////////////////////////////////////////////////////////////////

    function automatic chan_cfg_t cfg_from_bus(logic [31:0] d);
        chan_cfg_t c;
        c.att    = d[1:0];
        c.amp_en = d[2];
        c.led    = d[6:4];                                  // Red in bit 6
        return c;
    endfunction

    function automatic logic [31:0] readback_of(chan_cfg_t c);
        logic [31:0] r;
        r      = '0;
        r[6:4] = c.led;
        r[2]   = c.amp_en;
        r[1:0] = c.att;
        return r;
    endfunction

    // Pin rule per port with LEDs on when low
    function automatic ioexp_word_u model_word(chan_cfg_t a, chan_cfg_t b, logic [1:0] ovr);
        ioexp_word_u w;
        w.ports.port0 = {1'b0, a.amp_en, ~a.att[1], ~a.att[0],
                         1'b0, b.amp_en, ~b.att[1], ~b.att[0]};
        w.ports.port1 = {1'b0, ~(ovr[0] | a.led[2]), ~(ovr[1] | b.led[2]), 1'b0,
                         ~b.led[1] | ovr[1], ~b.led[0] | ovr[1],
                         ~a.led[1] | ovr[0], ~a.led[0] | ovr[0]};
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // I2C bus monitor sampling the lines mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset) begin
            if (mon_scl_q && sclk && mon_sda_q && !sda) begin          // Start
                mon_in_frame = 1'b1;
                mon_bit      = 0;
                mon_byte     = 0;
            end else if (mon_scl_q && sclk && !mon_sda_q && sda) begin // Stop
                if (mon_in_frame && mon_byte != 4)
                    stop_with_failure($sformatf("frame with %0d bytes instead of 4", mon_byte));
                if (mon_in_frame) begin
                    mon_word.ports.port0 = mon_bytes[2];
                    mon_word.ports.port1 = mon_bytes[3];
                    hdr_addr_q.push_back(mon_bytes[0]);
                    hdr_cmd_q.push_back(mon_bytes[1]);
                    rx_word_q.push_back(mon_word);
                end
                mon_in_frame = 1'b0;
            end else if (!mon_scl_q && sclk && mon_in_frame) begin     // SCL rise
                if (mon_bit < 8) begin
                    mon_shift = {mon_shift[6:0], sda};
                    mon_bit++;
                end else if (!sda || mon_byte > 3) begin
                    stop_with_failure("ACK slot not released or too many bytes in a frame");
                end else begin
                    mon_bytes[mon_byte] = mon_shift;
                    mon_byte++;
                    mon_bit = 0;
                end
            end
        end
        mon_scl_q = sclk;
        mon_sda_q = sda;
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB and wait tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_write(logic [31:0] addr, logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;                            // Access phase
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_read(logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = prdata;                                      // Combinational readback
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic write_chan(int ch, logic [31:0] data);
        apb_write({REGS_PAGE, (ch != 0) ? INB_OFFSET : INA_OFFSET}, data);
        if (ch != 0) inb_m = cfg_from_bus(data);
        else ina_m = cfg_from_bus(data);
    endtask

    task automatic check_regs();
        logic [31:0] rd;
        apb_read({REGS_PAGE, INA_OFFSET}, rd);
        check_rdata(rd, readback_of(ina_m), "INA");
        apb_read({REGS_PAGE, INB_OFFSET}, rd);
        check_rdata(rd, readback_of(inb_m), "INB");
    endtask

    // Wrong page or wrong offset but never a mapped register
    function automatic logic [31:0] unmapped_addr();
        logic [31:0] a;
        a = $urandom;
        if ($urandom_range(1, 0) == 0) begin
            a[31:12] = REGS_PAGE;                           // Right page, bad offset
            if (a[11:0] == INA_OFFSET || a[11:0] == INB_OFFSET)
                a[11:0] = a[11:0] + 12'h008;
        end else begin
            // Mapped offset on a foreign page
            a[11:0] = ($urandom_range(1, 0) == 0) ? INA_OFFSET : INB_OFFSET;
            if (a[31:12] == REGS_PAGE)
                a[31:12] = ~REGS_PAGE;
        end
        return a;
    endfunction

    task automatic wait_quiet();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            waited++;
            if (sclk && sda) quiet++;
            else quiet = 0;
            if (waited > WAIT_LIMIT)
                stop_with_failure("timeout: the I2C lines never went quiet");
        end
    endtask

    task automatic wait_frame_active();
        int waited;
        waited = 0;
        while (sclk) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                stop_with_failure("timeout: no I2C frame started after a settings change");
        end
    endtask

    // Check every queued header and keep the newest word
    task automatic drain_frames(output int count);
        count = 0;
        while (rx_word_q.size() > 0) begin
            check_hdr(hdr_addr_q.pop_front(), hdr_cmd_q.pop_front());
            last_word = rx_word_q.pop_front();
            count++;
        end
    endtask

    task automatic verify_settled();
        int frames;
        wait_quiet();
        drain_frames(frames);
        check_word(last_word, model_word(ina_m, inb_m, ovr_m));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        int          frames;
        apb_req   = '0;
        dor       = '0;
        reset     = 1'b1;
        ina_m     = '0;
        inb_m     = '0;
        ovr_m     = '0;
        last_word = '1;
        void'($urandom(80));
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (!(sclk && sda))
            stop_with_failure($sformatf("error at %0t: I2C lines not high after reset", $time));

        // Default word goes out once after reset
        wait_quiet();
        drain_frames(frames);
        if (frames == 0)
            stop_with_failure("no I2C frame was received after reset");
        check_word(last_word, model_word(ina_m, inb_m, ovr_m));

        // Random settings with readback and unmapped traffic
        for (int i = 0; i < N_RANDOM; i++) begin
            write_chan($urandom_range(1, 0), $urandom);
            check_regs();
            if (i % 3 == 0) begin
                apb_write(unmapped_addr(), $urandom);
                apb_read(unmapped_addr(), rd);
                check_rdata(rd, 32'h0, "unmapped");
                check_regs();                               // Still untouched
            end
            verify_settled();
        end

        // Overrange per channel with green and blue lit beforehand
        write_chan(0, 32'h0000_0035);
        write_chan(1, 32'h0000_0036);
        verify_settled();
        for (int c = 0; c < 2; c++) begin
            @(posedge clk);
            dor[c] <= 1'b1;
            ovr_m[c] = 1'b1;
            repeat (4 * HOLD_CYCLES) @(posedge clk);
            verify_settled();                               // Red on while green and blue go off
            @(posedge clk);
            dor[c] <= 1'b0;
            ovr_m[c] = 1'b0;
            repeat (HOLD_CYCLES + 2) @(posedge clk);
            verify_settled();
        end

        // Bursts landing in a running frame
        for (int b = 0; b < 3; b++) begin
            write_chan(0, readback_of(ina_m) ^ 32'h0000_0004);  // Sure to change the word
            wait_frame_active();
            repeat (5) write_chan($urandom_range(1, 0), $urandom);
            check_regs();
            verify_settled();
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/r24_status_top.sv
`default_nettype none

module r24_status_top #(
    parameter int         HOLD_CYCLES    = 16,
    parameter int         QUARTER_CYCLES = 4,
    parameter logic [6:0] DEV_ADDR       = 7'h20
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  r24_status_pkg::apb_req_t apb_req_i,
    output logic [31:0]              prdata_o,
    input  logic [1:0]               dor_i,
    output logic                     ioexp_sclk_o,
    output logic                     ioexp_sdata_o
);
    import r24_status_pkg::*;

    chan_cfg_t   ina_cfg;
    chan_cfg_t   inb_cfg;
    logic [1:0]  dor_hold;
    ioexp_word_u word;
    logic        word_stb;

    ////////////////////////////////////////////////////////////////////////////
    // Settings and overrange into the expander word
    ////////////////////////////////////////////////////////////////////////////

    apb_chan_regs regs_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .apb_req_i (apb_req_i),
        .prdata_o  (prdata_o),
        .ina_cfg_o (ina_cfg),
        .inb_cfg_o (inb_cfg)
    );

    overrange_stretch #(.HOLD_CYCLES(HOLD_CYCLES)) stretch_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .dor_i      (dor_i),
        .dor_hold_o (dor_hold)
    );

    ioexp_word_builder builder_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .ina_cfg_i  (ina_cfg),
        .inb_cfg_i  (inb_cfg),
        .dor_hold_i (dor_hold),
        .word_o     (word),
        .word_stb_o (word_stb)
    );

    // Expander lines
    i2c_ioexp_writer #(
        .QUARTER_CYCLES (QUARTER_CYCLES),
        .DEV_ADDR       (DEV_ADDR)
    ) writer_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .word_i     (word),
        .word_stb_i (word_stb),
        .sclk_o     (ioexp_sclk_o),
        .sdata_o    (ioexp_sdata_o)
    );

endmodule

`default_nettype wire

// File: rtl/i2c_ioexp_writer.sv
`default_nettype none

module i2c_ioexp_writer #(
    parameter int         QUARTER_CYCLES = 4,
    parameter logic [6:0] DEV_ADDR       = 7'h20
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  r24_status_pkg::ioexp_word_u word_i,
    input  logic                        word_stb_i,
    output logic                        sclk_o,
    output logic                        sdata_o
);
    import r24_status_pkg::*;

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    typedef enum logic [2:0] {ST_IDLE, ST_START, ST_BIT, ST_ACK, ST_STOP} phase_t;

    phase_t        phase;
    logic [QW-1:0] qcnt;         // Clocks within a quarter
    logic [1:0]    qtr;          // Quarter within a phase
    logic [2:0]    bit_cnt;
    logic [1:0]    byte_cnt;
    logic [7:0]    shreg;
    logic [7:0]    next_byte;
    ioexp_word_u   word_cur;     // Word of the frame on the wire
    ioexp_word_u   pend_word;
    logic          pend_vld;
    logic          qtick;
    logic          phase_end;
    logic          launch;
    logic          scl_d;
    logic          sda_d;

    assign qtick     = (phase != ST_IDLE) && (qcnt == QW'(QUARTER_CYCLES - 1));
    assign phase_end = qtick && (qtr == 2'd3);

    // New frame from idle, or straight after a stop when a word waits
    assign launch = (word_stb_i || pend_vld) &&
                    ((phase == ST_IDLE) || ((phase == ST_STOP) && phase_end));

    // Byte after the one just sent
    always_comb begin
        case (byte_cnt)
            2'd0:    next_byte = IOEXP_CMD_OUT0;
            2'd1:    next_byte = word_cur.ports.port0;
            default: next_byte = word_cur.ports.port1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Phase FSM and counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase    <= ST_IDLE;
            qcnt     <= '0;
            qtr      <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            pend_vld <= 1'b0;
        end else begin
            if (qtick) begin
                qcnt <= '0;
                qtr  <= qtr + 2'd1;
            end else if (phase != ST_IDLE) begin
                qcnt <= qcnt + QW'(1);
            end
            if (launch) begin
                phase <= ST_START;
                qcnt  <= '0;
                qtr   <= '0;
            end else if (phase_end) begin
                case (phase)
                    ST_START: begin
                        phase    <= ST_BIT;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                    ST_BIT: begin
                        if (bit_cnt == 3'd7) phase <= ST_ACK;
                        else bit_cnt <= bit_cnt + 3'd1;
                    end
                    ST_ACK: begin
                        if (byte_cnt == 2'd3) begin
                            phase <= ST_STOP;               // Port 1 was last
                        end else begin
                            phase    <= ST_BIT;
                            bit_cnt  <= '0;
                            byte_cnt <= byte_cnt + 2'd1;
                        end
                    end
                    default: phase <= ST_IDLE;              // Stop done
                endcase
            end
            // Pending slot, newest word wins
            if (launch) pend_vld <= 1'b0;
            else if (word_stb_i) pend_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) word_cur <= word_stb_i ? word_i : pend_word;
        if (word_stb_i) pend_word <= word_i;
        if (phase_end) begin
            case (phase)
                ST_START: shreg <= {DEV_ADDR, 1'b0};        // Write bit
                ST_BIT:   shreg <= {shreg[6:0], 1'b1};      // MSB first
                ST_ACK:   shreg <= next_byte;
                default:  shreg <= shreg;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Line levels per quarter
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        scl_d = 1'b1;
        sda_d = 1'b1;
        case (phase)
            ST_START: begin
                scl_d = (qtr != 2'd3);
                sda_d = (qtr < 2'd2);                        // Falls with SCL high
            end
            ST_BIT: begin
                scl_d = (qtr == 2'd1) || (qtr == 2'd2);
                sda_d = shreg[7];
            end
            ST_ACK:  scl_d = (qtr == 2'd1) || (qtr == 2'd2); // SDA left high
            ST_STOP: begin
                scl_d = (qtr != 2'd0);
                sda_d = (qtr >= 2'd2);                       // Rises with SCL high
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sclk_o  <= 1'b1;
            sdata_o <= 1'b1;
        end else begin
            sclk_o  <= scl_d;
            sdata_o <= sda_d;
        end
    end

    // Lines trail the phase by one clock
    sda_stable_while_scl_high: assert property (
        @(posedge clk) disable iff (reset_i)
        (sclk_o && $past(sclk_o) && ($past(phase) != ST_START) && ($past(phase) != ST_STOP))
        |-> $stable(sdata_o)
    );

endmodule

`default_nettype wire

// File: rtl/ioexp_word_builder.sv
`default_nettype none

module ioexp_word_builder (
    input  logic                        clk,
    input  logic                        reset_i,
    input  r24_status_pkg::chan_cfg_t   ina_cfg_i,
    input  r24_status_pkg::chan_cfg_t   inb_cfg_i,
    input  logic [1:0]                  dor_hold_i,
    output r24_status_pkg::ioexp_word_u word_o,
    output logic                        word_stb_o
);
    import r24_status_pkg::*;

    ioexp_word_u word_next;
    ioexp_word_u word_q;
    logic        word_stb_q;

    ////////////////////////////////////////////////////////////////////////////
    // Pin mapping, LEDs on when low
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Port 1, overrange lights red and blanks green and blue
        word_next.fields.led_com_a   = 1'b0;
        word_next.fields.ina_red_n   = ~(dor_hold_i[0] | ina_cfg_i.led[2]);
        word_next.fields.inb_red_n   = ~(dor_hold_i[1] | inb_cfg_i.led[2]);
        word_next.fields.led_com_b   = 1'b0;
        word_next.fields.inb_green_n = ~inb_cfg_i.led[1] | dor_hold_i[1];
        word_next.fields.inb_blue_n  = ~inb_cfg_i.led[0] | dor_hold_i[1];
        word_next.fields.ina_green_n = ~ina_cfg_i.led[1] | dor_hold_i[0];
        word_next.fields.ina_blue_n  = ~ina_cfg_i.led[0] | dor_hold_i[0];
        // Port 0, attenuator pins inverted
        word_next.fields.p0_spare7   = 1'b0;
        word_next.fields.ina_amp_en  = ina_cfg_i.amp_en;
        word_next.fields.ina_att_n   = ~ina_cfg_i.att;
        word_next.fields.p0_spare3   = 1'b0;
        word_next.fields.inb_amp_en  = inb_cfg_i.amp_en;
        word_next.fields.inb_att_n   = ~inb_cfg_i.att;
    end

    // All ones never matches a real word, so the default goes out after reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            word_q     <= '1;
            word_stb_q <= 1'b0;
        end else begin
            word_q     <= word_next;
            word_stb_q <= (word_next != word_q);  // Change detect
        end
    end

    assign word_o     = word_q;
    assign word_stb_o = word_stb_q;

endmodule

`default_nettype wire

// File: rtl/overrange_stretch.sv
`default_nettype none

module overrange_stretch #(
    parameter int HOLD_CYCLES = 16
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic [1:0] dor_i,        // Bit 0 is channel A
    output logic [1:0] dor_hold_o
);

    // Counter must hold the reload value itself
    localparam int CW = $clog2(HOLD_CYCLES + 1);

    logic [CW-1:0] hold_cnt [2];

    ////////////////////////////////////////////////////////////////////////////
    // One down-counter per channel
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_cnt[0] <= '0;
            hold_cnt[1] <= '0;
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (dor_i[ch]) begin
                    hold_cnt[ch] <= CW'(HOLD_CYCLES);     // Reload while overrange
                end else if (hold_cnt[ch] != '0) begin
                    hold_cnt[ch] <= hold_cnt[ch] - CW'(1);
                end
            end
        end
    end

    // Live flag plus tail
    assign dor_hold_o[0] = dor_i[0] || (hold_cnt[0] != '0);
    assign dor_hold_o[1] = dor_i[1] || (hold_cnt[1] != '0);

endmodule

`default_nettype wire

// File: rtl/apb_chan_regs.sv
`default_nettype none

module apb_chan_regs (
    input  logic                      clk,
    input  logic                      reset_i,
    input  r24_status_pkg::apb_req_t  apb_req_i,
    output logic [31:0]               prdata_o,
    output r24_status_pkg::chan_cfg_t ina_cfg_o,
    output r24_status_pkg::chan_cfg_t inb_cfg_o
);
    import r24_status_pkg::*;

    logic      page_hit;
    logic      sel_ina;
    logic      sel_inb;
    logic      wr_en;
    logic      rd_en;
    chan_cfg_t ina_cfg_q;
    chan_cfg_t inb_cfg_q;
    chan_cfg_t wr_cfg;
    chan_cfg_t rd_cfg;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    assign page_hit = (apb_req_i.paddr[31:12] == REGS_PAGE);
    assign sel_ina  = page_hit && (apb_req_i.paddr[11:0] == INA_OFFSET);
    assign sel_inb  = page_hit && (apb_req_i.paddr[11:0] == INB_OFFSET);

    // Access phase only, no wait states
    assign wr_en = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
    assign rd_en = apb_req_i.psel && apb_req_i.penable && !apb_req_i.pwrite;

    // Bus layout 6:4 led, 2 amp_en, 1:0 att
    assign wr_cfg = {apb_req_i.pwdata[1:0], apb_req_i.pwdata[2], apb_req_i.pwdata[6:4]};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ina_cfg_q <= '0;
            inb_cfg_q <= '0;
        end else if (wr_en) begin
            if (sel_ina) ina_cfg_q <= wr_cfg;
            if (sel_inb) inb_cfg_q <= wr_cfg;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////////////////////

    assign rd_cfg = sel_ina ? ina_cfg_q : inb_cfg_q;

    always_comb begin
        prdata_o = '0;                       // Unmapped reads give zero
        if (rd_en && (sel_ina || sel_inb)) begin
            prdata_o[6:4] = rd_cfg.led;
            prdata_o[2]   = rd_cfg.amp_en;
            prdata_o[1:0] = rd_cfg.att;
        end
    end

    assign ina_cfg_o = ina_cfg_q;
    assign inb_cfg_o = inb_cfg_q;

    // Access phase must follow a setup phase
    apb_setup_before_access: assert property (
        @(posedge clk) disable iff (reset_i)
        (apb_req_i.psel && apb_req_i.penable) |-> $past(apb_req_i.psel)
    );

endmodule

`default_nettype wire

// File: rtl/r24_status_pkg.sv
`default_nettype none

package r24_status_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // APB request and channel settings
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Front-end settings of one ADC input
    typedef struct packed {
        logic [1:0] att;     // Attenuator steps
        logic       amp_en;  // Input amplifier on
        logic [2:0] led;     // Red, green, blue
    } chan_cfg_t;

    localparam logic [19:0] REGS_PAGE  = 20'h43C04;
    localparam logic [11:0] INA_OFFSET = 12'h000;
    localparam logic [11:0] INB_OFFSET = 12'h004;

    // Output port 0, expander auto-increments into port 1
    localparam logic [7:0] IOEXP_CMD_OUT0 = 8'h02;

    ////////////////////////////////////////////////////////////////////////////
    // Expander word, seen as raw ports or as pins
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [7:0] port1;
        logic [7:0] port0;
    } ioexp_ports_t;

    // LED pins are active low
    typedef struct packed {
        logic       led_com_a;   // P1.7
        logic       ina_red_n;
        logic       inb_red_n;
        logic       led_com_b;   // P1.4
        logic       inb_green_n;
        logic       inb_blue_n;
        logic       ina_green_n;
        logic       ina_blue_n;
        logic       p0_spare7;
        logic       ina_amp_en;
        logic [1:0] ina_att_n;
        logic       p0_spare3;
        logic       inb_amp_en;
        logic [1:0] inb_att_n;
    } ioexp_fields_t;

    typedef union packed {
        ioexp_ports_t  ports;
        ioexp_fields_t fields;
    } ioexp_word_u;

endpackage

`default_nettype wire
